//--- files.f
design/snd_map_pkg.sv
design/snd_field_pkg.sv
design/snd_bus_decode.sv
design/snd_channel_regs.sv
design/snd_wave_ram.sv
design/snd_ctrl_regs.sv
design/snd_field_unpack.sv
design/snd_regs.sv
testbench/snd_regs_chk.sv
testbench/snd_regs_tb.sv

//--- Makefile
TOP = snd_regs_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Run ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/snd_regs_tb.sv
`timescale 1ns/100ps
`default_nettype none

module snd_regs_tb;

   localparam int PERIOD = 4;          // ns
   localparam int MAX_CYCLES = 400;    // Tests need about 100 cycles

   logic                          clk;
   logic                          arst_n;
   logic [15:0]                   addr;
   logic [7:0]                    data;
   logic                          w_enable;
   snd_field_pkg::tone_fields_t   ch1;
   snd_field_pkg::tone_fields_t   ch2;
   snd_field_pkg::wave_fields_t   ch3;
   snd_field_pkg::noise_fields_t  ch4;
   logic [3:0]                    trig;
   logic [127:0]                  samples;
   snd_field_pkg::mixer_t         mixer;
   logic                          master_on;

   int seed = 12750;
   int cycles = 0;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int errs_at_start = 0;

   logic [4:0][7:0]  ch1_sh;    // Shadow of NR10..NR14
   logic [4:0][7:0]  ch4_sh;    // Shadow of FF1F..FF23
   logic [0:15][7:0] wave_sh;   // Byte 0 on top, as on samples
   logic [7:0]       nr50_sh;
   logic [7:0]       nr51_sh;

   snd_regs u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // Register layout, fields in struct order
   function automatic snd_field_pkg::tone_fields_t tone_expect(input logic [4:0][7:0] b);
      return snd_field_pkg::tone_fields_t'({b[0][6:0], b[1], b[2], b[4][6],
                                            b[4][2:0], b[3]});
   endfunction

   function automatic snd_field_pkg::noise_fields_t noise_expect(input logic [4:0][7:0] b);
      return snd_field_pkg::noise_fields_t'({b[1][5:0], b[2], b[3], b[4][6]});
   endfunction

   // NR50 and NR51 bit layout
   function automatic snd_field_pkg::mixer_t mixer_expect(input logic [7:0] nr50,
                                                          input logic [7:0] nr51);
      snd_field_pkg::mixer_t m;
      m.so2_vin = nr50[7];
      m.so2_level = nr50[6:4];
      m.so1_vin = nr50[3];
      m.so1_level = nr50[2:0];
      m.so2_en = nr51[7:4];      // Upper nibble routes to SO2
      m.so1_en = nr51[3:0];
      return m;
   endfunction

   function automatic logic len_en_of(input int i);
      case (i)
         0: return ch1.len_en;
         1: return ch2.len_en;
         2: return ch3.len_en;
         default: return ch4.len_en;
      endcase
   endfunction

   task automatic expect_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // Called at 1 ns past an edge, returns 1 ns past the accepting edge
   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      addr = a;
      data = d;
      w_enable = 1'b1;
      @(posedge clk);
      #1;
      w_enable = 1'b0;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      int total;
      total = errors + u_dut.u_chk.fails;   // Includes concurrent assertions
      tests++;
      $display("Test %0d %s: %0d errors", tests, name, total - errs_at_start);
      errs_at_start = total;
   endtask

   initial begin
      logic [7:0] d;
      logic [15:0] nrx4;
      arst_n = 1'b0;
      addr = '0;
      data = '0;
      w_enable = 1'b0;
      ch1_sh = '0;
      ch4_sh = '0;
      wave_sh = '0;
      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // Everything zero, channel writes blocked until NR52 bit 7
      expect_eq("master_on", 128'(master_on), 128'(0));
      expect_eq("ch1", 128'(ch1), 128'(0));
      expect_eq("ch2", 128'(ch2), 128'(0));
      expect_eq("ch3", 128'(ch3), 128'(0));
      expect_eq("ch4", 128'(ch4), 128'(0));
      expect_eq("trig", 128'(trig), 128'(0));
      expect_eq("mixer", 128'(mixer), 128'(0));
      expect_eq("samples", samples, 128'(0));
      bus_write(snd_map_pkg::CHAN_BASE + 16'd1, 8'($random(seed)) | 8'h01);
      expect_eq("ch1", 128'(ch1), 128'(0));
      finish_test("reset and master off");

      bus_write(snd_map_pkg::CTRL_BASE + 16'd2, 8'h80);
      expect_eq("master_on", 128'(master_on), 128'(1));
      for (int k = 0; k < 5; k++) begin
         d = 8'($random(seed));
         bus_write(snd_map_pkg::CHAN_BASE + 16'(k), d);
         ch1_sh[k] = d;
         expect_eq("ch1", 128'(ch1), 128'(tone_expect(ch1_sh)));
      end
      for (int k = 0; k < 5; k++) begin
         d = 8'($random(seed));
         bus_write(snd_map_pkg::CHAN_BASE + 16'(15 + k), d);   // FF1F slot first
         ch4_sh[k] = d;
         expect_eq("ch4", 128'(ch4), 128'(noise_expect(ch4_sh)));
      end
      nr50_sh = 8'($random(seed));
      nr51_sh = 8'($random(seed));
      bus_write(snd_map_pkg::CTRL_BASE, nr50_sh);
      bus_write(snd_map_pkg::CTRL_BASE + 16'd1, nr51_sh);
      expect_eq("mixer", 128'(mixer), 128'(mixer_expect(nr50_sh, nr51_sh)));
      finish_test("channel 1 and 4 fields");

      for (int i = 0; i < snd_map_pkg::NUM_CHANNELS; i++) begin
         nrx4 = snd_map_pkg::CHAN_BASE + 16'(5 * i + 4);
         bus_write(nrx4, 8'hC0 | (8'($random(seed)) & 8'h07));
         expect_eq("trig", 128'(trig), 128'(4'b0001 << i));
         expect_eq("len_en", 128'(len_en_of(i)), 128'(1));
         idle_cycle();
         expect_eq("trig", 128'(trig), 128'(0));   // Pulse lasts one cycle
         bus_write(nrx4, 8'($random(seed)) & 8'h07);
         expect_eq("trig", 128'(trig), 128'(0));
         expect_eq("len_en", 128'(len_en_of(i)), 128'(0));
      end
      finish_test("trigger pulses");

      // First pass with master on, second with master off
      for (int p = 0; p < 2; p++) begin
         if (p == 1) begin
            bus_write(snd_map_pkg::CTRL_BASE + 16'd2, 8'h00);
            expect_eq("master_on", 128'(master_on), 128'(0));
         end
         for (int k = 0; k < snd_map_pkg::WAVE_BYTES; k++) begin
            d = 8'($random(seed));
            bus_write(snd_map_pkg::WAVE_BASE + 16'(k), d);
            wave_sh[k] = d;
         end
         expect_eq("samples", samples, wave_sh);
      end
      finish_test("wave RAM");

      bus_write(snd_map_pkg::CTRL_BASE + 16'd2, 8'h80);
      bus_write(snd_map_pkg::CHAN_BASE + 16'd2, 8'($random(seed)) | 8'h10);
      bus_write(snd_map_pkg::CHAN_BASE + 16'd16, 8'($random(seed)) | 8'h01);   // NR41
      bus_write(snd_map_pkg::CTRL_BASE, 8'($random(seed)) | 8'h01);
      bus_write(snd_map_pkg::CTRL_BASE + 16'd2, 8'h00);
      idle_cycle();                                      // Clear lands on this edge
      expect_eq("ch1", 128'(ch1), 128'(0));
      expect_eq("ch4", 128'(ch4), 128'(0));
      expect_eq("mixer", 128'(mixer), 128'(0));
      bus_write(snd_map_pkg::CHAN_BASE + 16'd2, 8'hF3);   // Ignored, master off
      expect_eq("ch1", 128'(ch1), 128'(0));
      bus_write(snd_map_pkg::CTRL_BASE, 8'h77);
      expect_eq("mixer", 128'(mixer), 128'(0));
      d = 8'($random(seed));
      bus_write(snd_map_pkg::WAVE_BASE + 16'd15, d);
      wave_sh[15] = d;
      expect_eq("samples", samples, wave_sh);
      finish_test("master off clear");

      errors += u_dut.u_chk.fails;
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/snd_regs_chk.sv
`timescale 1ns/100ps
`default_nettype none

// Port level timing rules of the sound register bank
module snd_regs_chk (
   input wire logic                      clk,
   input wire logic                      arst_n,
   input wire logic [15:0]               addr,
   input wire logic [7:0]                data,
   input wire logic                      w_enable,
   input snd_field_pkg::tone_fields_t    ch1,
   input snd_field_pkg::noise_fields_t   ch4,
   input wire logic [3:0]                trig,
   input wire logic [127:0]              samples,
   input snd_field_pkg::mixer_t          mixer,
   input wire logic                      master_on
);

   localparam logic [15:0] NR52 = snd_map_pkg::CTRL_BASE + 16'd2;

   logic wr_on;     // Write with the master enable set
   int   fails = 0; // Assertion failure count

   assign wr_on = w_enable && master_on;

   a_master: assert property (@(posedge clk) disable iff (!arst_n)
      (w_enable && addr == NR52) |=> (master_on == $past(data[7])))
      else begin
         $error("master_on does not follow NR52 bit 7");
         fails++;
      end

   // NR13 low frequency byte
   a_freq_lo: assert property (@(posedge clk) disable iff (!arst_n)
      (wr_on && addr == snd_map_pkg::CHAN_BASE + 16'd3) |=> (ch1.freq[7:0] == $past(data)))
      else begin
         $error("ch1 freq low byte wrong after NR13 write");
         fails++;
      end

   a_freq_hi: assert property (@(posedge clk) disable iff (!arst_n)
      (wr_on && addr == snd_map_pkg::CHAN_BASE + 16'd4)
      |=> (ch1.freq[10:8] == $past(data[2:0]) && ch1.len_en == $past(data[6])))
      else begin
         $error("ch1 freq high bits or length enable wrong after NR14 write");
         fails++;
      end

   // NR43 at FF22
   a_noise: assert property (@(posedge clk) disable iff (!arst_n)
      (wr_on && addr == snd_map_pkg::CHAN_BASE + 16'd18)
      |=> ({ch4.shift_clk, ch4.width_7, ch4.div_ratio} == $past(data)))
      else begin
         $error("ch4 polynomial counter fields wrong after NR43 write");
         fails++;
      end

   a_wave: assert property (@(posedge clk) disable iff (!arst_n)
      (w_enable && addr[15:4] == 12'hFF3)   // FF30..FF3F
      |=> (samples[8 * (15 - $past(addr[3:0])) +: 8] == $past(data)))
      else begin
         $error("wave byte not found at its sample position");
         fails++;
      end

   // Zeroed one edge after the master off write
   a_clear: assert property (@(posedge clk) disable iff (!arst_n)
      (wr_on && addr == NR52 && !data[7]) |=> ##1 (ch1 == '0 && ch4 == '0 && mixer == '0))
      else begin
         $error("channel fields or mixer not cleared after master off");
         fails++;
      end

   for (genvar i = 0; i < snd_map_pkg::NUM_CHANNELS; i++) begin : g_trig
      a_trig: assert property (@(posedge clk) disable iff (!arst_n)
         trig[i] == $past(wr_on && data[7]
                          && addr == snd_map_pkg::CHAN_BASE + 16'(5 * i + 4)))
         else begin
            $error("trig pulse does not match the initial bit write");
            fails++;
         end
   end

endmodule

bind snd_regs snd_regs_chk u_chk (
   .clk (clk), .arst_n (arst_n), .addr (addr), .data (data), .w_enable (w_enable),
   .ch1 (ch1), .ch4 (ch4), .trig (trig), .samples (samples), .mixer (mixer),
   .master_on (master_on)
);

`default_nettype wire

//--- design/snd_regs.sv
`timescale 1ns/100ps
`default_nettype none

// Sound register bank, CPU write port to typed fields
module snd_regs (
   input  wire logic                     clk,
   input  wire logic                     arst_n,
   input  wire logic [15:0]              addr,
   input  wire logic [7:0]               data,
   input  wire logic                     w_enable,
   output snd_field_pkg::tone_fields_t   ch1,
   output snd_field_pkg::tone_fields_t   ch2,
   output snd_field_pkg::wave_fields_t   ch3,
   output snd_field_pkg::noise_fields_t  ch4,
   output logic [3:0]                    trig,      // Initial bit pulses, bit i is channel i+1
   output logic [127:0]                  samples,
   output snd_field_pkg::mixer_t         mixer,
   output logic                          master_on
);

   snd_field_pkg::wr_req_t     req;
   logic                       clear;
   snd_field_pkg::chan_bytes_t chan_bytes [snd_map_pkg::NUM_CHANNELS];

   snd_bus_decode u_decode (
      .addr      (addr),
      .data      (data),
      .w_enable  (w_enable),
      .master_on (master_on),
      .req       (req)
   );

   snd_ctrl_regs u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .mixer     (mixer),
      .master_on (master_on),
      .clear     (clear)
   );

   snd_wave_ram u_wave (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .samples   (samples)
   );

   for (genvar i = 0; i < snd_map_pkg::NUM_CHANNELS; i++) begin : g_chan
      snd_channel_regs u_chan (
         .clk    (clk),
         .arst_n (arst_n),
         .index  (2'(i)),
         .req    (req),
         .clear  (clear),
         .bytes  (chan_bytes[i]),
         .trig   (trig[i])
      );
   end

   snd_field_unpack u_unpack (
      .ch1_bytes (chan_bytes[0]),
      .ch2_bytes (chan_bytes[1]),
      .ch3_bytes (chan_bytes[2]),
      .ch4_bytes (chan_bytes[3]),
      .ch1       (ch1),
      .ch2       (ch2),
      .ch3       (ch3),
      .ch4       (ch4)
   );

endmodule

`default_nettype wire

//--- design/snd_field_unpack.sv
`timescale 1ns/100ps
`default_nettype none

// Raw channel bytes to typed fields
module snd_field_unpack (
   input  snd_field_pkg::chan_bytes_t     ch1_bytes,
   input  snd_field_pkg::chan_bytes_t     ch2_bytes,
   input  snd_field_pkg::chan_bytes_t     ch3_bytes,
   input  snd_field_pkg::chan_bytes_t     ch4_bytes,
   output snd_field_pkg::tone_fields_t    ch1,
   output snd_field_pkg::tone_fields_t    ch2,
   output snd_field_pkg::wave_fields_t    ch3,
   output snd_field_pkg::noise_fields_t   ch4
);

   // Shared by both tone channels
   function automatic snd_field_pkg::tone_fields_t unpack_tone(
      input snd_field_pkg::chan_bytes_t b,
      input logic has_sweep
   );
      snd_field_pkg::tone_fields_t t;
      t.sweep_time = has_sweep ? b[0][6:4] : 3'd0;   // NR10
      t.sweep_dec = has_sweep ? b[0][3] : 1'b0;
      t.sweep_shift = has_sweep ? b[0][2:0] : 3'd0;
      t.duty = b[1][7:6];
      t.length = b[1][5:0];
      t.init_vol = b[2][7:4];                        // Envelope byte
      t.env_inc = b[2][3];
      t.env_step = b[2][2:0];
      t.len_en = b[4][6];
      t.freq = {b[4][2:0], b[3]};                    // Hi 3 bits, then lo byte
      return t;
   endfunction

   always_comb begin
      ch1 = unpack_tone(ch1_bytes, 1'b1);
      ch2 = unpack_tone(ch2_bytes, 1'b0);   // FF15 slot is unused

      ch3.enable = ch3_bytes[0][7];         // NR30
      ch3.length = ch3_bytes[1];
      ch3.out_level = ch3_bytes[2][6:5];
      ch3.len_en = ch3_bytes[4][6];
      ch3.freq = {ch3_bytes[4][2:0], ch3_bytes[3]};

      // FF1F slot unused, NR41 is byte 1
      ch4.length = ch4_bytes[1][5:0];
      ch4.init_vol = ch4_bytes[2][7:4];
      ch4.env_inc = ch4_bytes[2][3];
      ch4.env_step = ch4_bytes[2][2:0];
      ch4.shift_clk = ch4_bytes[3][7:4];    // NR43 polynomial counter
      ch4.width_7 = ch4_bytes[3][3];
      ch4.div_ratio = ch4_bytes[3][2:0];
      ch4.len_en = ch4_bytes[4][6];
   end

endmodule

`default_nettype wire

//--- design/snd_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

// NR50, NR51 and the NR52 master bit
module snd_ctrl_regs (
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  snd_field_pkg::wr_req_t    req,
   output snd_field_pkg::mixer_t     mixer,
   output logic                      master_on,
   output logic                      clear     // One cycle, wipes the channel blocks
);

   typedef enum logic {
      MASTER_OFF = 1'b0,
      MASTER_ON  = 1'b1
   } master_state_e;

   master_state_e state;
   logic [7:0]    nr50;
   logic [7:0]    nr51;
   logic          wr;

   assign wr = req.valid && (req.region == snd_map_pkg::REGION_CTRL);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= MASTER_OFF;
         nr50 <= '0;
         nr51 <= '0;
         clear <= 1'b0;
      end else begin
         clear <= 1'b0;
         if (wr && (req.offset == 4'd2)) begin   // NR52
            if (req.data[snd_map_pkg::MASTER_BIT]) begin
               state <= MASTER_ON;
            end else begin
               state <= MASTER_OFF;
               clear <= (state == MASTER_ON);    // Only on the on to off edge
            end
         end
         // Zeroed on the same edge as the channel bytes
         if (clear) begin
            nr50 <= '0;
            nr51 <= '0;
         end else if (wr && (req.offset == 4'd0)) begin
            nr50 <= req.data;
         end else if (wr && (req.offset == 4'd1)) begin
            nr51 <= req.data;
         end
      end
   end

   assign master_on = (state == MASTER_ON);
   assign mixer = snd_field_pkg::mixer_t'({nr50, nr51});   // Layout mirrors the bytes

endmodule

`default_nettype wire

//--- design/snd_wave_ram.sv
`timescale 1ns/100ps
`default_nettype none

// Wave pattern RAM, FF30..FF3F
module snd_wave_ram (
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  snd_field_pkg::wr_req_t    req,
   output logic [127:0]              samples
);

   // Ascending index so byte 0 lands in the top bits
   logic [0:snd_map_pkg::WAVE_BYTES-1][7:0] ram;
   logic wr;

   assign wr = req.valid && (req.region == snd_map_pkg::REGION_WAVE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ram <= '0;
      end else if (wr) begin
         ram[req.offset] <= req.data;   // No master gating here
      end
   end

   // Upper nibble of FF30 is sample 0
   assign samples = ram;

endmodule

`default_nettype wire

//--- design/snd_channel_regs.sv
`timescale 1ns/100ps
`default_nettype none

// One channel's NRx0..NRx4 store plus trigger
module snd_channel_regs (
   input  wire logic                     clk,
   input  wire logic                     arst_n,
   input  wire logic [1:0]               index,   // Position in the channel array
   input  snd_field_pkg::wr_req_t        req,
   input  wire logic                     clear,   // From NR52 master off
   output snd_field_pkg::chan_bytes_t    bytes,
   output logic                          trig
);

   logic hit;
   logic last_byte;   // NRx4, holds the initial bit

   // Gating on master is done upstream
   assign hit = req.valid && (req.region == snd_map_pkg::REGION_CHAN)
                && (req.chan == index);
   assign last_byte = req.offset == 4'(snd_map_pkg::CHAN_BYTES - 1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bytes <= '0;
         trig <= 1'b0;
      end else begin
         trig <= hit && last_byte && req.data[7];   // One cycle restart pulse
         if (clear) begin
            bytes <= '0;
         end else if (hit) begin
            for (int b = 0; b < snd_map_pkg::CHAN_BYTES; b++) begin
               if (req.offset == 4'(b)) begin
                  bytes[b] <= req.data;
               end
            end
            // Initial bit is write-only, never kept
            if (last_byte) begin
               bytes[snd_map_pkg::CHAN_BYTES-1] <= {1'b0, req.data[6:0]};
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/snd_bus_decode.sv
`timescale 1ns/100ps
`default_nettype none

// Address classification and master enable gating
module snd_bus_decode (
   input  wire logic [15:0]          addr,
   input  wire logic [7:0]           data,
   input  wire logic                 w_enable,
   input  wire logic                 master_on,
   output snd_field_pkg::wr_req_t    req
);

   logic [15:0] chan_dist;   // Distance from NR10
   logic [15:0] wave_dist;
   logic [15:0] ctrl_dist;
   logic        nr52_hit;    // Reachable while master is off

   // Below-base addresses wrap to large values and miss
   assign chan_dist = addr - snd_map_pkg::CHAN_BASE;
   assign wave_dist = addr - snd_map_pkg::WAVE_BASE;
   assign ctrl_dist = addr - snd_map_pkg::CTRL_BASE;

   always_comb begin
      req = '0;
      req.data = data;
      req.region = snd_map_pkg::REGION_NONE;
      if (chan_dist < 16'(snd_map_pkg::NUM_CHANNELS * snd_map_pkg::CHAN_BYTES)) begin
         req.region = snd_map_pkg::REGION_CHAN;
         // Last block whose base is not above the address wins
         for (int c = 0; c < snd_map_pkg::NUM_CHANNELS; c++) begin
            if (chan_dist >= 16'(c * snd_map_pkg::CHAN_BYTES)) begin
               req.chan = 2'(c);
               req.offset = 4'(chan_dist - 16'(c * snd_map_pkg::CHAN_BYTES));
            end
         end
      end else if (ctrl_dist < 16'd3) begin   // NR50, NR51, NR52
         req.region = snd_map_pkg::REGION_CTRL;
         req.offset = ctrl_dist[3:0];
      end else if (wave_dist < 16'(snd_map_pkg::WAVE_BYTES)) begin
         req.region = snd_map_pkg::REGION_WAVE;
         req.offset = wave_dist[3:0];
      end

      nr52_hit = (req.region == snd_map_pkg::REGION_CTRL) && (req.offset == 4'd2);

      // Master off leaves only NR52 and wave RAM writable
      req.valid = w_enable && (req.region != snd_map_pkg::REGION_NONE)
                  && (master_on || nr52_hit
                      || (req.region == snd_map_pkg::REGION_WAVE));
   end

endmodule

`default_nettype wire

//--- design/snd_field_pkg.sv
`default_nettype none

// Bus request and register field layouts
package snd_field_pkg;

   // One decoded CPU write
   typedef struct packed {
      logic                valid;     // Strobe hit a live register
      snd_map_pkg::region_e region;
      logic [1:0]          chan;      // Channel block, 0 is channel 1
      logic [3:0]          offset;    // Byte within block, wave RAM or NR50..NR52
      logic [7:0]          data;
   } wr_req_t;

   // Raw NRx0..NRx4, index 0 is NRx0
   typedef logic [snd_map_pkg::CHAN_BYTES-1:0][7:0] chan_bytes_t;

   // Channels 1 and 2
   typedef struct packed {
      logic [2:0]  sweep_time;   // Channel 1 only
      logic        sweep_dec;    // 1 means frequency goes down
      logic [2:0]  sweep_shift;
      logic [1:0]  duty;         // 12.5/25/50/75 percent
      logic [5:0]  length;
      logic [3:0]  init_vol;
      logic        env_inc;      // Envelope direction, 1 is up
      logic [2:0]  env_step;     // 0 stops the envelope
      logic        len_en;       // Stop when length expires
      logic [10:0] freq;
   } tone_fields_t;

   // Channel 3
   typedef struct packed {
      logic        enable;       // NR30 bit 7
      logic [7:0]  length;
      logic [1:0]  out_level;    // Mute, 100, 50, 25 percent
      logic        len_en;
      logic [10:0] freq;
   } wave_fields_t;

   // Channel 4
   typedef struct packed {
      logic [5:0]  length;
      logic [3:0]  init_vol;
      logic        env_inc;
      logic [2:0]  env_step;
      logic [3:0]  shift_clk;    // Polynomial counter shift clock
      logic        width_7;      // 1 selects 7-bit LFSR, else 15
      logic [2:0]  div_ratio;
      logic        len_en;
   } noise_fields_t;

   // NR50 then NR51, bit order kept
   typedef struct packed {
      logic        so2_vin;      // Cartridge Vin to SO2
      logic [2:0]  so2_level;
      logic        so1_vin;
      logic [2:0]  so1_level;
      logic [3:0]  so2_en;       // Bit i routes channel i+1
      logic [3:0]  so1_en;
   } mixer_t;

endpackage

`default_nettype wire

//--- design/snd_map_pkg.sv
`default_nettype none

// Sound unit address map, fixed by the console
package snd_map_pkg;

   localparam int NUM_CHANNELS = 4;            // Tone+sweep, tone, wave, noise
   localparam int CHAN_BYTES = 5;              // NRx0..NRx4 per channel

   // First channel byte, NR10
   localparam logic [15:0] CHAN_BASE = 16'hFF10;

   // Wave pattern RAM window
   localparam logic [15:0] WAVE_BASE = 16'hFF30;
   localparam int WAVE_BYTES = 16;             // 32 samples of 4 bits

   // NR50 here, NR51 and NR52 right after
   localparam logic [15:0] CTRL_BASE = 16'hFF24;

   localparam int MASTER_BIT = 7;              // NR52 all sound on/off

   // Which block an address lands in
   typedef enum logic [1:0] {
      REGION_NONE = 2'd0,                      // Outside the sound map, or the FF27..FF2F gap
      REGION_CHAN = 2'd1,
      REGION_WAVE = 2'd2,
      REGION_CTRL = 2'd3
   } region_e;

endpackage

`default_nettype wire
